//--- flit_buffer.sv
`timescale 1ns/1ps

module flit_buffer (
    input  logic                          clk,
    input  logic                          reset,
    // write side
    input  flit_buffer_pkg::stored_flit_t din,
    input  flit_buffer_pkg::vc_mask_t     vc_num_wr,
    input  logic                          wr_en,
    // read side
    input  flit_buffer_pkg::vc_mask_t     vc_num_rd,
    input  logic                          rd_en,
    output flit_buffer_pkg::stored_flit_t dout,
    // status per vc
    output flit_buffer_pkg::vc_mask_t     vc_not_empty,
    output flit_buffer_pkg::vc_mask_t     vc_has_packet
);

    // pointer control to ram
    flit_buffer_pkg::ram_addr_t wr_addr;
    flit_buffer_pkg::ram_addr_t rd_addr;
    logic                       ram_wr;
    logic                       ram_rd;

    // pointer control to packet tracker
    flit_buffer_pkg::vc_mask_t  wr_accept;
    flit_buffer_pkg::vc_mask_t  rd_accept;

    // pointers, depths and accept decisions
    vc_ptr_ctrl u_ptr (
        .clk          (clk),
        .reset        (reset),
        .vc_num_wr    (vc_num_wr),
        .vc_num_rd    (vc_num_rd),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .wr_addr      (wr_addr),
        .rd_addr      (rd_addr),
        .ram_wr       (ram_wr),
        .ram_rd       (ram_rd),
        .wr_accept    (wr_accept),
        .rd_accept    (rd_accept),
        .vc_not_empty (vc_not_empty)
    );

    // shared flit store, dout comes straight from its read register
    flit_ram u_ram (
        .clk     (clk),
        .reset   (reset),
        .wr_addr (wr_addr),
        .rd_addr (rd_addr),
        .ram_wr  (ram_wr),
        .ram_rd  (ram_rd),
        .wr_data (din),
        .rd_data (dout)
    );

    // whole-packet flags
    // sees tails going in on din and coming out on dout
    pkt_count_tracker u_pkt (
        .clk           (clk),
        .reset         (reset),
        .wr_accept     (wr_accept),
        .rd_accept     (rd_accept),
        .wr_tail       (din.tail),
        .rd_flit       (dout),
        .vc_has_packet (vc_has_packet)
    );

endmodule

//--- flit_buffer_assert.sv
`timescale 1ns/1ps
`include "flit_buffer_defs.svh"

module flit_buffer_assert (
    input logic                       clk,
    input logic                       reset,
    input logic                       wr_en,
    input flit_buffer_pkg::vc_mask_t  vc_num_wr,
    input flit_buffer_pkg::vc_mask_t  wr_accept,
    input flit_buffer_pkg::vc_mask_t  rd_accept,
    input flit_buffer_pkg::slot_ptr_t wr_ptr [`FB_NUM_VC],
    input flit_buffer_pkg::depth_t    depth  [`FB_NUM_VC]
);

    // failures so far, read by the testbench
    int unsigned fail_count = 0;

    for (genvar i = 0; i < `FB_NUM_VC; i++) begin : g_vc
        // occupancy never above slot count
        depth_in_range: assert property (@(posedge clk) disable iff (reset)
            depth[i] <= flit_buffer_pkg::depth_t'(`FB_VC_DEPTH))
        else begin
            fail_count++;
            $error("vc %0d depth %0d is above the slot count", i, depth[i]);
        end

        // accepted write moves the write pointer one slot, wrapping
        wr_ptr_advance: assert property (@(posedge clk) disable iff (reset)
            wr_accept[i] |=>
                wr_ptr[i] == flit_buffer_pkg::slot_ptr_t'($past(wr_ptr[i]) + 1'b1))
        else begin
            fail_count++;
            $error("vc %0d write pointer did not advance after an accepted write", i);
        end

        // write into a full vc with no read beside it is dropped
        full_wr_hold: assert property (@(posedge clk) disable iff (reset)
            (wr_en && vc_num_wr[i] && !rd_accept[i] &&
             depth[i] == flit_buffer_pkg::depth_t'(`FB_VC_DEPTH)) |=> $stable(wr_ptr[i]))
        else begin
            fail_count++;
            $error("vc %0d write pointer moved on a write to a full vc", i);
        end
    end

endmodule

bind vc_ptr_ctrl flit_buffer_assert u_assert (
    .clk       (clk),
    .reset     (reset),
    .wr_en     (wr_en),
    .vc_num_wr (vc_num_wr),
    .wr_accept (wr_accept),
    .rd_accept (rd_accept),
    .wr_ptr    (wr_ptr),
    .depth     (depth)
);

//--- flit_buffer_defs.svh
`ifndef FLIT_BUFFER_DEFS_SVH
`define FLIT_BUFFER_DEFS_SVH

// virtual channels sharing one input port
`define FB_NUM_VC 2

// flit slots per virtual channel
`define FB_VC_DEPTH 4

// payload bits carried by each flit
`define FB_PAYLOAD_W 32

// slot pointer width, log2 of FB_VC_DEPTH
`define FB_PTR_W 2

// binary vc index width, log2 of FB_NUM_VC
`define FB_VC_IDX_W 1

// complete packets held per vc
// worst case is one single-flit packet in every slot
`define FB_PKT_CNT_W 3

`endif

//--- flit_buffer_pkg.sv
package flit_buffer_pkg;

    `include "flit_buffer_defs.svh"

    // one bit per vc, one-hot for selects
    typedef logic [`FB_NUM_VC-1:0] vc_mask_t;

    // binary vc number
    typedef logic [`FB_VC_IDX_W-1:0] vc_idx_t;

    // slot position inside one vc
    typedef logic [`FB_PTR_W-1:0] slot_ptr_t;

    // vc occupancy, 0 up to FB_VC_DEPTH inclusive
    typedef logic [`FB_PTR_W:0] depth_t;

    // shared ram address, vc index on top of slot pointer
    typedef logic [`FB_VC_IDX_W+`FB_PTR_W-1:0] ram_addr_t;

    typedef logic [`FB_PAYLOAD_W-1:0] payload_t;

    // flit as held in the ram
    // the vc number is implied by the address and is not stored
    typedef struct packed {
        logic     head;
        logic     tail;
        payload_t payload;
    } stored_flit_t;

    // packets held per vc
    typedef logic [`FB_PKT_CNT_W-1:0] pkt_cnt_t;

endpackage

//--- flit_ram.sv
`timescale 1ns/1ps
`include "flit_buffer_defs.svh"

module flit_ram (
    input  logic                         clk,
    input  logic                         reset,
    input  flit_buffer_pkg::ram_addr_t   wr_addr,
    input  flit_buffer_pkg::ram_addr_t   rd_addr,
    input  logic                         ram_wr,
    input  logic                         ram_rd,
    input  flit_buffer_pkg::stored_flit_t wr_data,
    output flit_buffer_pkg::stored_flit_t rd_data
);

    // all vcs side by side, vc index selects the region
    localparam int RAM_DEPTH = `FB_NUM_VC * `FB_VC_DEPTH;

    flit_buffer_pkg::stored_flit_t mem [RAM_DEPTH];

    // output register
    flit_buffer_pkg::stored_flit_t rd_q;

    // storage array, write port
    always_ff @(posedge clk) begin
        if (ram_wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read
    // same-address write in this cycle is not seen, old flit comes out
    // this is what a full vc with read and write together relies on
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_q <= '0;
        end else if (ram_rd) begin
            rd_q <= mem[rd_addr];
        end
    end

    // holds the last flit read until the next accepted read
    assign rd_data = rd_q;

endmodule

//--- pkt_count_tracker.sv
`timescale 1ns/1ps
`include "flit_buffer_defs.svh"

module pkt_count_tracker (
    input  logic                          clk,
    input  logic                          reset,
    input  flit_buffer_pkg::vc_mask_t     wr_accept,
    input  flit_buffer_pkg::vc_mask_t     rd_accept,
    input  logic                          wr_tail,
    input  flit_buffer_pkg::stored_flit_t rd_flit,
    output flit_buffer_pkg::vc_mask_t     vc_has_packet
);

    // complete packets per vc
    flit_buffer_pkg::pkt_cnt_t pkt_cnt [`FB_NUM_VC];

    // read accepts delayed to line up with the ram output
    flit_buffer_pkg::vc_mask_t rd_accept_q;

    // per-vc count steps
    flit_buffer_pkg::vc_mask_t cnt_inc;
    flit_buffer_pkg::vc_mask_t cnt_dec;

    // a tail entering closes a packet
    assign cnt_inc = wr_tail ? wr_accept : '0;

    // a tail leaving shows on rd_flit one cycle after its read
    assign cnt_dec = rd_flit.tail ? rd_accept_q : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_accept_q <= '0;
        end else begin
            rd_accept_q <= rd_accept;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `FB_NUM_VC; i++) begin
                pkt_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `FB_NUM_VC; i++) begin
                // both at once leave the count as is
                case ({cnt_inc[i], cnt_dec[i]})
                    2'b10:   pkt_cnt[i] <= pkt_cnt[i] + 1'b1;
                    2'b01:   pkt_cnt[i] <= pkt_cnt[i] - 1'b1;
                    default: pkt_cnt[i] <= pkt_cnt[i];
                endcase
            end
        end
    end

    // whole packet waiting somewhere in the vc
    always_comb begin
        for (int i = 0; i < `FB_NUM_VC; i++) begin
            vc_has_packet[i] = (pkt_cnt[i] != '0);
        end
    end

endmodule

//--- sim.f
+incdir+.
flit_buffer_pkg.sv
vc_ptr_ctrl.sv
flit_ram.sv
pkt_count_tracker.sv
flit_buffer.sv
flit_buffer_assert.sv
tb_flit_buffer.sv

//--- tb_flit_buffer.sv
`timescale 1ns/1ps
`include "flit_buffer_defs.svh"

module tb_flit_buffer;

    localparam int CLK_NS = 4;
    localparam int RESET_CYCLES = 5;
    localparam int RANDOM_CYCLES = 300;
    localparam int CMP_W = $bits(flit_buffer_pkg::stored_flit_t);
    // cycles per test in run order, random test last
    localparam int TEST_CYCLES = RESET_CYCLES + 2 + 10 + 18 + 14 + 14 + RANDOM_CYCLES + 2;
    localparam int MARGIN_CYCLES = 100;
    localparam int WATCHDOG_NS = (TEST_CYCLES + MARGIN_CYCLES) * CLK_NS;

    logic                          clk;
    logic                          reset;
    flit_buffer_pkg::stored_flit_t din;
    flit_buffer_pkg::vc_mask_t     vc_num_wr;
    flit_buffer_pkg::vc_mask_t     vc_num_rd;
    logic                          wr_en;
    logic                          rd_en;
    flit_buffer_pkg::stored_flit_t dout;
    flit_buffer_pkg::vc_mask_t     vc_not_empty;
    flit_buffer_pkg::vc_mask_t     vc_has_packet;

    // reference queues and packet counts per vc
    flit_buffer_pkg::stored_flit_t ref_q [`FB_NUM_VC][$];
    int                            pkt_cnt [`FB_NUM_VC];
    // tail reads, count drops one edge later
    flit_buffer_pkg::vc_mask_t     tail_rd;

    // outputs expected once the last driven cycle is taken
    flit_buffer_pkg::stored_flit_t exp_dout;
    flit_buffer_pkg::vc_mask_t     exp_not_empty;
    flit_buffer_pkg::vc_mask_t     exp_has_packet;

    string       test_name;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;
    int unsigned assert_base;

    flit_buffer uut (
        .clk           (clk),
        .reset         (reset),
        .din           (din),
        .vc_num_wr     (vc_num_wr),
        .wr_en         (wr_en),
        .vc_num_rd     (vc_num_rd),
        .rd_en         (rd_en),
        .dout          (dout),
        .vc_not_empty  (vc_not_empty),
        .vc_has_packet (vc_has_packet)
    );

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    function automatic flit_buffer_pkg::stored_flit_t make_flit(
        input logic head, input logic tail, input flit_buffer_pkg::payload_t payload
    );
        flit_buffer_pkg::stored_flit_t f;
        f.head = head;
        f.tail = tail;
        f.payload = payload;
        return f;
    endfunction

    task automatic expect_eq(input string what, input logic [CMP_W-1:0] exp,
                             input logic [CMP_W-1:0] act);
        assert (act === exp) else begin
            $display("** Error %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_outputs();
        expect_eq("dout", CMP_W'(exp_dout), CMP_W'(dout));
        expect_eq("vc_not_empty", CMP_W'(exp_not_empty), CMP_W'(vc_not_empty));
        expect_eq("vc_has_packet", CMP_W'(exp_has_packet), CMP_W'(vc_has_packet));
    endtask

    // drive one cycle, check the cycle before, then step the model
    task automatic cycle(input logic wr, input int vw, input flit_buffer_pkg::stored_flit_t flit,
                         input logic rd, input int vr);
        logic rd_ok;
        logic wr_ok;
        @(posedge clk);
        wr_en     <= wr;
        vc_num_wr <= flit_buffer_pkg::vc_mask_t'(1 << vw);
        din       <= flit;
        rd_en     <= rd;
        vc_num_rd <= flit_buffer_pkg::vc_mask_t'(1 << vr);
        // previous cycle has settled by the falling edge
        @(negedge clk);
        check_outputs();
        // acceptance on the coming edge, read first
        rd_ok = rd && (ref_q[vr].size() > 0);
        wr_ok = wr && ((ref_q[vw].size() < `FB_VC_DEPTH) || (rd_ok && vr == vw));
        for (int i = 0; i < `FB_NUM_VC; i++) begin
            if (tail_rd[i]) begin
                pkt_cnt[i]--;
            end
        end
        tail_rd = '0;
        if (rd_ok) begin
            exp_dout = ref_q[vr].pop_front();
            tail_rd[vr] = exp_dout.tail;
        end
        if (wr_ok) begin
            ref_q[vw].push_back(flit);
            if (flit.tail) begin
                pkt_cnt[vw]++;
            end
        end
        for (int i = 0; i < `FB_NUM_VC; i++) begin
            exp_not_empty[i] = (ref_q[i].size() > 0);
            exp_has_packet[i] = (pkt_cnt[i] != 0);
        end
    endtask

    task automatic write_flit(input int vc, input flit_buffer_pkg::stored_flit_t flit);
        cycle(1'b1, vc, flit, 1'b0, 0);
    endtask

    task automatic read_flit(input int vc);
        cycle(1'b0, 0, '0, 1'b1, vc);
    endtask

    // two idle cycles also cover the late count drop
    task automatic idle(input int n);
        repeat (n) cycle(1'b0, 0, '0, 1'b0, 0);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
        assert_base = uut.u_ptr.u_assert.fail_count;
    endtask

    task automatic finish_test();
        test_errors += int'(uut.u_ptr.u_assert.fail_count - assert_base);
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_errors);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        flit_buffer_pkg::stored_flit_t rnd_flit;
        logic                          rnd_wr;
        logic                          rnd_rd;
        int                            rnd_vw;
        int                            rnd_vr;
        void'($urandom(23));
        reset = 1'b1;
        wr_en = 1'b0;
        rd_en = 1'b0;
        din = '0;
        vc_num_wr = '0;
        vc_num_rd = '0;
        exp_dout = '0;
        exp_not_empty = '0;
        exp_has_packet = '0;
        tail_rd = '0;
        total_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int i = 0; i < `FB_NUM_VC; i++) begin
            pkt_cnt[i] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // everything cleared
        start_test("reset");
        idle(2);
        finish_test();

        // head, two body flits, tail through vc0
        start_test("fifo_order");
        write_flit(0, make_flit(1'b1, 1'b0, 32'ha000_0001));
        write_flit(0, make_flit(1'b0, 1'b0, 32'ha000_0002));
        write_flit(0, make_flit(1'b0, 1'b0, 32'ha000_0003));
        write_flit(0, make_flit(1'b0, 1'b1, 32'ha000_0004));
        repeat (4) read_flit(0);
        idle(2);
        finish_test();

        // interleaved packets, vc1 drained first
        start_test("vc_isolation");
        for (int i = 0; i < 4; i++) begin
            write_flit(0, make_flit(i == 0, i == 3, 32'hb000_0100 + i));
            write_flit(1, make_flit(i == 0, i == 3, 32'hb000_0200 + i));
        end
        repeat (4) read_flit(1);
        repeat (4) read_flit(0);
        idle(2);
        finish_test();

        // last two writes hit a full vc, then reads past empty
        start_test("back_pressure");
        for (int i = 0; i < 6; i++) begin
            write_flit(1, make_flit(i == 0, i == 3 || i == 5, 32'hc000_0000 + i));
        end
        repeat (5) read_flit(1);
        read_flit(0);
        idle(2);
        finish_test();

        // read and write together at depth 2 and at full
        start_test("simultaneous");
        write_flit(0, make_flit(1'b1, 1'b0, 32'hd000_0000));
        write_flit(0, make_flit(1'b0, 1'b0, 32'hd000_0001));
        cycle(1'b1, 0, make_flit(1'b0, 1'b0, 32'hd000_0002), 1'b1, 0);
        cycle(1'b1, 0, make_flit(1'b0, 1'b1, 32'hd000_0003), 1'b1, 0);
        write_flit(0, make_flit(1'b1, 1'b0, 32'hd000_0004));
        write_flit(0, make_flit(1'b0, 1'b1, 32'hd000_0005));
        cycle(1'b1, 0, make_flit(1'b1, 1'b0, 32'hd000_0006), 1'b1, 0);
        cycle(1'b1, 0, make_flit(1'b0, 1'b1, 32'hd000_0007), 1'b1, 0);
        repeat (4) read_flit(0);
        idle(2);
        finish_test();

        // mixed traffic on both vcs
        start_test("random_traffic");
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            rnd_wr = 1'($urandom_range(0, 1));
            rnd_rd = 1'($urandom_range(0, 1));
            rnd_vw = $urandom_range(0, `FB_NUM_VC - 1);
            rnd_vr = $urandom_range(0, `FB_NUM_VC - 1);
            rnd_flit.head = 1'($urandom_range(0, 1));
            rnd_flit.tail = ($urandom_range(0, 3) == 0);
            rnd_flit.payload = $urandom;
            cycle(rnd_wr, rnd_vw, rnd_flit, rnd_rd, rnd_vr);
        end
        idle(2);
        finish_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- vc_ptr_ctrl.sv
`timescale 1ns/1ps
`include "flit_buffer_defs.svh"

module vc_ptr_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  flit_buffer_pkg::vc_mask_t  vc_num_wr,
    input  flit_buffer_pkg::vc_mask_t  vc_num_rd,
    input  logic                       wr_en,
    input  logic                       rd_en,
    output flit_buffer_pkg::ram_addr_t wr_addr,
    output flit_buffer_pkg::ram_addr_t rd_addr,
    output logic                       ram_wr,
    output logic                       ram_rd,
    output flit_buffer_pkg::vc_mask_t  wr_accept,
    output flit_buffer_pkg::vc_mask_t  rd_accept,
    output flit_buffer_pkg::vc_mask_t  vc_not_empty
);

    // per-vc queue state
    flit_buffer_pkg::slot_ptr_t wr_ptr [`FB_NUM_VC];
    flit_buffer_pkg::slot_ptr_t rd_ptr [`FB_NUM_VC];
    flit_buffer_pkg::depth_t    depth  [`FB_NUM_VC];

    // selects qualified by their enables
    flit_buffer_pkg::vc_mask_t wr_sel;
    flit_buffer_pkg::vc_mask_t rd_sel;

    // binary vc numbers for address build
    flit_buffer_pkg::vc_idx_t wr_idx;
    flit_buffer_pkg::vc_idx_t rd_idx;

    // or of the bit positions that are set
    // exact for a one-hot mask
    function automatic flit_buffer_pkg::vc_idx_t onehot_to_idx(
        input flit_buffer_pkg::vc_mask_t mask
    );
        flit_buffer_pkg::vc_idx_t idx;
        idx = '0;
        for (int i = 0; i < `FB_NUM_VC; i++) begin
            if (mask[i]) begin
                idx = idx | flit_buffer_pkg::vc_idx_t'(i);
            end
        end
        return idx;
    endfunction

    assign wr_sel = wr_en ? vc_num_wr : '0;
    assign rd_sel = rd_en ? vc_num_rd : '0;

    assign wr_idx = onehot_to_idx(vc_num_wr);
    assign rd_idx = onehot_to_idx(vc_num_rd);

    // full and empty gating
    always_comb begin
        for (int i = 0; i < `FB_NUM_VC; i++) begin
            // nothing to read from an empty vc
            rd_accept[i] = rd_sel[i] && (depth[i] != '0);
            // full vc takes a write only when a read frees a slot in the same cycle
            wr_accept[i] = wr_sel[i] &&
                           ((depth[i] != flit_buffer_pkg::depth_t'(`FB_VC_DEPTH)) ||
                            rd_accept[i]);
            vc_not_empty[i] = (depth[i] != '0);
        end
    end

    // ram strobes and addresses
    assign ram_wr  = |wr_accept;
    assign ram_rd  = |rd_accept;
    assign wr_addr = {wr_idx, wr_ptr[wr_idx]};
    assign rd_addr = {rd_idx, rd_ptr[rd_idx]};

    // pointers wrap at FB_VC_DEPTH by width
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `FB_NUM_VC; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                depth[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < `FB_NUM_VC; i++) begin
                if (wr_accept[i]) begin
                    wr_ptr[i] <= wr_ptr[i] + 1'b1;
                end
                if (rd_accept[i]) begin
                    rd_ptr[i] <= rd_ptr[i] + 1'b1;
                end
                // depth moves only when one side acts alone
                case ({wr_accept[i], rd_accept[i]})
                    2'b10:   depth[i] <= depth[i] + 1'b1;
                    2'b01:   depth[i] <= depth[i] - 1'b1;
                    default: depth[i] <= depth[i];
                endcase
            end
        end
    end

endmodule
